// ==== hw/oled_map_pkg.sv ====
//####################################################################
// shared types, I2C protocol bytes, panel geometry and the sequencer
// state encoding for the OLED display-map streamer
// referenced by scoped names from every RTL module
//####################################################################

package oled_map_pkg;

    // one byte on the I2C bus
    typedef logic [7:0] byte_t;
    // page index, 8 pages of 8 pixel rows
    typedef logic [2:0] page_t;
    // column index across the panel
    typedef logic [6:0] col_t;

    // panel geometry
    localparam int map_pages = 8;
    localparam int map_cols  = 128;
    localparam page_t last_page = page_t'(map_pages - 1);
    localparam col_t  last_col  = col_t'(map_cols - 1);

    // 7-bit address 0x3c shifted left with write bit
    localparam byte_t oled_addr = 8'h78;

    // control bytes that open a command or data stream
    localparam byte_t ctrl_cmd  = 8'h00;
    localparam byte_t ctrl_data = 8'h40;

    // page address command, page number in bits 2:0
    localparam byte_t cmd_page_base = 8'hb0;
    // column start split into low and high nibble commands
    localparam byte_t cmd_col_low   = 8'h00;
    localparam byte_t cmd_col_high  = 8'h10;

    // transaction sequencer states
    typedef enum logic [4:0] {
        idle           = 5'd0,
        // command transaction
        grant_cmd      = 5'd1,
        start_cmd      = 5'd2,
        addr_ack_cmd   = 5'd3,
        send_cmd_ctrl  = 5'd4,
        cmd_ctrl_ack   = 5'd5,
        set_page       = 5'd6,
        page_ack       = 5'd7,
        set_col_low    = 5'd8,
        col_low_ack    = 5'd9,
        set_col_high   = 5'd10,
        col_high_ack   = 5'd11,
        stop_cmd       = 5'd12,
        stop_cmd_done  = 5'd13,
        // data transaction
        grant_data     = 5'd14,
        start_data     = 5'd15,
        addr_ack_data  = 5'd16,
        send_data_ctrl = 5'd17,
        data_ctrl_ack  = 5'd18,
        send_data      = 5'd19,
        data_ack       = 5'd20,
        stop_data      = 5'd21,
        stop_data_done = 5'd22,
        // page loop and end of run
        check_pages    = 5'd23,
        map_done       = 5'd24
    } tx_state_e;

endpackage

// ==== hw/maze_map_rom.sv ====
//####################################################################
// maze bitmap for the OLED panel, generated from a fixed rule
// combinational lookup of one map byte by page and column
//####################################################################

module maze_map_rom (
    input  oled_map_pkg::page_t page,
    input  oled_map_pkg::col_t  col,
    output oled_map_pkg::byte_t map_byte
);

    logic edge_col;
    logic inner_wall;

    // outer left and right walls
    assign edge_col = (col == '0) || (col == oled_map_pkg::last_col);

    // vertical walls every 16 columns, only on even pages
    assign inner_wall = (col[3:0] == 4'd0) && !page[0];

    always_comb begin
        if (edge_col) begin
            map_byte = 8'hff;
        end else if (inner_wall) begin
            map_byte = 8'hff;
        end else if (page == '0) begin
            // top wall on the first pixel row of page 0
            map_byte = 8'h01;
        end else if (page == oled_map_pkg::last_page) begin
            // bottom wall on the last pixel row of page 7
            map_byte = 8'h80;
        end else begin
            // open corridor
            map_byte = 8'h00;
        end
    end

endmodule

// ==== hw/map_cursor.sv ====
//####################################################################
// page and column walk for the map streamer
// steps on single-cycle pulses from the sequencer and reports
// the end of a row and the end of the whole map
//####################################################################

module map_cursor (
    input  logic                clk,
    input  logic                reset,
    input  logic                cursor_clear,
    input  logic                col_step,
    input  logic                page_step,
    output oled_map_pkg::page_t page,
    output oled_map_pkg::col_t  col,
    output logic                row_end,
    output logic                map_end
);

    // set once the last page is stepped past
    logic pages_done;

    // column counter, wraps back to zero after the last column
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col <= '0;
        end else if (cursor_clear) begin
            col <= '0;
        end else if (col_step) begin
            if (col == oled_map_pkg::last_col) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // page counter and done flag
    // a 3-bit page cannot reach 8 so the flag marks the end
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            page       <= '0;
            pages_done <= 1'b0;
        end else if (cursor_clear) begin
            page       <= '0;
            pages_done <= 1'b0;
        end else if (page_step) begin
            page <= page + 1'b1;
            if (page == oled_map_pkg::last_page) begin
                pages_done <= 1'b1;
            end
        end
    end

    assign row_end = (col == oled_map_pkg::last_col);
    assign map_end = pages_done;

endmodule

// ==== hw/map_tx_sequencer.sv ====
//####################################################################
// transaction FSM of the map streamer
// per page one command transaction then one data transaction
// over a busy/done handshake with the I2C controller
//####################################################################

module map_tx_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                draw_map_req,
    input  logic                oled_granted,
    input  logic                i2c_busy,
    input  logic                i2c_done,
    input  oled_map_pkg::page_t page,
    input  oled_map_pkg::byte_t map_byte,
    input  logic                row_end,
    input  logic                map_end,
    output logic                cursor_clear,
    output logic                col_step,
    output logic                page_step,
    output logic                map_busy,
    output logic                oled_req,
    output logic                i2c_start,
    output logic                i2c_stop,
    output logic                i2c_write,
    output oled_map_pkg::byte_t i2c_data_in
);

    oled_map_pkg::tx_state_e state;
    oled_map_pkg::tx_state_e next_state;

    // holds a done pulse until the state moves on
    logic done_latch;
    logic state_change;

    assign state_change = (next_state != state);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= oled_map_pkg::idle;
            done_latch <= 1'b0;
        end else begin
            state <= next_state;
            // a done that lands early is kept for the ack state
            if (i2c_done) begin
                done_latch <= 1'b1;
            end else if (state_change) begin
                done_latch <= 1'b0;
            end
        end
    end

    // next state
    // send states leave on busy, ack states on the latched done
    always_comb begin
        next_state = state;
        case (state)
            oled_map_pkg::idle:
                if (draw_map_req) next_state = oled_map_pkg::grant_cmd;

            // command transaction
            oled_map_pkg::grant_cmd:
                if (oled_granted) next_state = oled_map_pkg::start_cmd;
            oled_map_pkg::start_cmd:
                if (i2c_busy) next_state = oled_map_pkg::addr_ack_cmd;
            oled_map_pkg::addr_ack_cmd:
                if (done_latch) next_state = oled_map_pkg::send_cmd_ctrl;
            oled_map_pkg::send_cmd_ctrl:
                if (i2c_busy) next_state = oled_map_pkg::cmd_ctrl_ack;
            oled_map_pkg::cmd_ctrl_ack:
                if (done_latch) next_state = oled_map_pkg::set_page;
            oled_map_pkg::set_page:
                if (i2c_busy) next_state = oled_map_pkg::page_ack;
            oled_map_pkg::page_ack:
                if (done_latch) next_state = oled_map_pkg::set_col_low;
            oled_map_pkg::set_col_low:
                if (i2c_busy) next_state = oled_map_pkg::col_low_ack;
            oled_map_pkg::col_low_ack:
                if (done_latch) next_state = oled_map_pkg::set_col_high;
            oled_map_pkg::set_col_high:
                if (i2c_busy) next_state = oled_map_pkg::col_high_ack;
            oled_map_pkg::col_high_ack:
                if (done_latch) next_state = oled_map_pkg::stop_cmd;
            oled_map_pkg::stop_cmd:
                if (!i2c_busy) next_state = oled_map_pkg::stop_cmd_done;
            oled_map_pkg::stop_cmd_done:
                if (done_latch) next_state = oled_map_pkg::grant_data;

            // data transaction
            oled_map_pkg::grant_data:
                if (oled_granted) next_state = oled_map_pkg::start_data;
            oled_map_pkg::start_data:
                if (i2c_busy) next_state = oled_map_pkg::addr_ack_data;
            oled_map_pkg::addr_ack_data:
                if (done_latch) next_state = oled_map_pkg::send_data_ctrl;
            oled_map_pkg::send_data_ctrl:
                if (i2c_busy) next_state = oled_map_pkg::data_ctrl_ack;
            oled_map_pkg::data_ctrl_ack:
                if (done_latch) next_state = oled_map_pkg::send_data;
            oled_map_pkg::send_data:
                if (i2c_busy) next_state = oled_map_pkg::data_ack;
            oled_map_pkg::data_ack:
                // last column closes the data transaction
                if (done_latch) begin
                    next_state = row_end ? oled_map_pkg::stop_data : oled_map_pkg::send_data;
                end
            oled_map_pkg::stop_data:
                if (!i2c_busy) next_state = oled_map_pkg::stop_data_done;
            oled_map_pkg::stop_data_done:
                if (done_latch) next_state = oled_map_pkg::check_pages;

            // one cycle after page_step the cursor flag is valid
            oled_map_pkg::check_pages:
                next_state = map_end ? oled_map_pkg::map_done : oled_map_pkg::grant_cmd;
            // sticky until reset
            oled_map_pkg::map_done:
                next_state = oled_map_pkg::map_done;
            default:
                next_state = oled_map_pkg::idle;
        endcase
    end

    // cursor pulses on the exit cycle of a state
    assign cursor_clear = (state == oled_map_pkg::idle) && state_change;
    assign col_step     = (state == oled_map_pkg::data_ack) && state_change;
    assign page_step    = (state == oled_map_pkg::stop_data_done) && state_change;

    assign map_busy = (state != oled_map_pkg::idle) && (state != oled_map_pkg::map_done);
    // bus request only while the requester still holds draw_map_req
    assign oled_req = map_busy && draw_map_req;

    // strobes and byte selection toward the I2C controller
    always_comb begin
        i2c_start   = 1'b0;
        i2c_stop    = 1'b0;
        i2c_write   = 1'b0;
        i2c_data_in = '0;
        case (state)
            oled_map_pkg::start_cmd,
            oled_map_pkg::start_data: begin
                i2c_start   = 1'b1;
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::oled_addr;
            end
            oled_map_pkg::send_cmd_ctrl: begin
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::ctrl_cmd;
            end
            oled_map_pkg::set_page: begin
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::cmd_page_base | oled_map_pkg::byte_t'(page);
            end
            oled_map_pkg::set_col_low: begin
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::cmd_col_low;
            end
            oled_map_pkg::set_col_high: begin
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::cmd_col_high;
            end
            oled_map_pkg::send_data_ctrl: begin
                i2c_write   = 1'b1;
                i2c_data_in = oled_map_pkg::ctrl_data;
            end
            // map byte straight from the ROM at the cursor position
            oled_map_pkg::send_data: begin
                i2c_write   = 1'b1;
                i2c_data_in = map_byte;
            end
            oled_map_pkg::stop_cmd,
            oled_map_pkg::stop_data: begin
                i2c_stop = 1'b1;
            end
            default: begin
                i2c_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/oled_map_display_controller.sv ====
//####################################################################
// top level of the OLED display-map streamer
// on a draw request it takes the shared I2C bus and writes the
// maze map page by page through an external I2C controller
//####################################################################

module oled_map_display_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                draw_map_req,
    input  logic                oled_granted,
    input  logic                i2c_busy,
    input  logic                i2c_done,
    output logic                map_busy,
    output logic                oled_req,
    output logic                i2c_start,
    output logic                i2c_stop,
    output logic                i2c_write,
    output oled_map_pkg::byte_t i2c_data_in
);

    // cursor control from the sequencer
    logic cursor_clear;
    logic col_step;
    logic page_step;

    // cursor position and flags
    oled_map_pkg::page_t page;
    oled_map_pkg::col_t  col;
    logic                row_end;
    logic                map_end;

    // ROM byte at the cursor
    oled_map_pkg::byte_t map_byte;

    map_tx_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .draw_map_req (draw_map_req),
        .oled_granted (oled_granted),
        .i2c_busy     (i2c_busy),
        .i2c_done     (i2c_done),
        .page         (page),
        .map_byte     (map_byte),
        .row_end      (row_end),
        .map_end      (map_end),
        .cursor_clear (cursor_clear),
        .col_step     (col_step),
        .page_step    (page_step),
        .map_busy     (map_busy),
        .oled_req     (oled_req),
        .i2c_start    (i2c_start),
        .i2c_stop     (i2c_stop),
        .i2c_write    (i2c_write),
        .i2c_data_in  (i2c_data_in)
    );

    map_cursor u_cursor (
        .clk          (clk),
        .reset        (reset),
        .cursor_clear (cursor_clear),
        .col_step     (col_step),
        .page_step    (page_step),
        .page         (page),
        .col          (col),
        .row_end      (row_end),
        .map_end      (map_end)
    );

    maze_map_rom u_map_rom (
        .page     (page),
        .col      (col),
        .map_byte (map_byte)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//####################################################################
// free-running testbench clock, period of 100 time units
//####################################################################

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        // half period
        forever #50 clk = ~clk;
    end

endmodule

// ==== testbench/i2c_master_model.sv ====
//####################################################################
// behavioral I2C controller and bus arbiter for the map streamer
// answers strobes with busy then done after set delays, with optional
// jitter, and reports every bus event on the log outputs
//####################################################################

module i2c_master_model (
    input  logic                clk,
    input  logic                reset,
    input  int                  grant_delay,
    input  int                  busy_delay,
    input  int                  done_delay,
    input  logic                jitter,
    input  logic                oled_req,
    input  logic                i2c_start,
    input  logic                i2c_stop,
    input  logic                i2c_write,
    input  oled_map_pkg::byte_t i2c_data_in,
    output logic                oled_granted,
    output logic                i2c_busy,
    output logic                i2c_done,
    output logic                log_valid,
    output logic                log_start,
    output logic                log_stop,
    output oled_map_pkg::byte_t log_byte
);

    typedef enum logic [1:0] {bus_idle, bus_wait, bus_hold, bus_finish} bus_phase_e;

    bus_phase_e  phase;
    int          bus_count;
    int          grant_count;
    logic        grant_armed;
    logic [31:0] lfsr = 32'h7748_9ac3;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // 0 to 3 extra cycles, one step per bit taken
    function automatic int jitter_cycles();
        int extra;
        extra = 0;
        if (jitter) begin
            for (int i = 0; i < 2; i++) begin
                extra = extra | (int'(lfsr[0]) << i);
                lfsr  = lfsr_step(lfsr);
            end
        end
        return extra;
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            phase        <= bus_idle;
            bus_count    <= 0;
            grant_count  <= 0;
            grant_armed  <= 1'b0;
            oled_granted <= 1'b0;
            i2c_busy     <= 1'b0;
            i2c_done     <= 1'b0;
            log_valid    <= 1'b0;
            log_start    <= 1'b0;
            log_stop     <= 1'b0;
            log_byte     <= '0;
        end else begin
            log_valid <= 1'b0;
            i2c_done  <= 1'b0;
            // arbiter, the bus is taken back after every stop
            if (!oled_req || (i2c_stop && phase == bus_idle)) begin
                oled_granted <= 1'b0;
                grant_armed  <= 1'b0;
            end else if (!oled_granted && !grant_armed) begin
                grant_armed <= 1'b1;
                grant_count <= grant_delay + jitter_cycles();
            end else if (grant_armed) begin
                if (grant_count == 0) begin
                    oled_granted <= 1'b1;
                    grant_armed  <= 1'b0;
                end else begin
                    grant_count <= grant_count - 1;
                end
            end
            // controller, one transfer at a time
            case (phase)
                bus_idle: begin
                    if (i2c_write || i2c_stop) begin
                        log_valid <= 1'b1;
                        log_start <= i2c_start;
                        log_stop  <= i2c_stop;
                        log_byte  <= i2c_data_in;
                        bus_count <= busy_delay + jitter_cycles();
                        phase     <= bus_wait;
                    end
                end
                bus_wait: begin
                    if (bus_count == 0) begin
                        i2c_busy  <= 1'b1;
                        bus_count <= done_delay + jitter_cycles();
                        phase     <= bus_hold;
                    end else begin
                        bus_count <= bus_count - 1;
                    end
                end
                bus_hold: begin
                    // busy falls together with the done pulse
                    if (bus_count == 0) begin
                        i2c_busy <= 1'b0;
                        i2c_done <= 1'b1;
                        phase    <= bus_finish;
                    end else begin
                        bus_count <= bus_count - 1;
                    end
                end
                default: begin
                    phase <= bus_idle;
                end
            endcase
        end
    end

endmodule

// ==== testbench/tb_oled_map.sv ====
//####################################################################
// testbench for the OLED display-map streamer
// runs each line of the vector file against the I2C controller model
// and checks every bus event against the command and map rules
//####################################################################

module tb_oled_map;

    logic                clk;
    logic                reset;
    logic                draw_map_req;
    logic                oled_granted;
    logic                i2c_busy;
    logic                i2c_done;
    logic                map_busy;
    logic                oled_req;
    logic                i2c_start;
    logic                i2c_stop;
    logic                i2c_write;
    oled_map_pkg::byte_t i2c_data_in;

    // model settings for the current run
    int   grant_delay;
    int   busy_delay;
    int   done_delay;
    logic jitter;

    // bus events seen by the model
    logic                log_valid;
    logic                log_start;
    logic                log_stop;
    oled_map_pkg::byte_t log_byte;

    // six fields per vector line
    int vec_fields[$];
    // bit 10 map byte, bit 9 stop, bit 8 start, bits 7:0 byte
    int exp_events[$];

    int         start_count;
    int         stop_count;
    int         write_count;
    logic [7:0] checksum;
    int         check_count;
    int         error_count;
    int         cycle_count;
    int         cycle_limit;
    logic       limit_ready;

    tb_clock_gen u_clock_gen (.clk(clk));

    i2c_master_model u_i2c_model (
        .clk          (clk),
        .reset        (reset),
        .grant_delay  (grant_delay),
        .busy_delay   (busy_delay),
        .done_delay   (done_delay),
        .jitter       (jitter),
        .oled_req     (oled_req),
        .i2c_start    (i2c_start),
        .i2c_stop     (i2c_stop),
        .i2c_write    (i2c_write),
        .i2c_data_in  (i2c_data_in),
        .oled_granted (oled_granted),
        .i2c_busy     (i2c_busy),
        .i2c_done     (i2c_done),
        .log_valid    (log_valid),
        .log_start    (log_start),
        .log_stop     (log_stop),
        .log_byte     (log_byte)
    );

    oled_map_display_controller u_oled_map_display_controller (
        .clk          (clk),
        .reset        (reset),
        .draw_map_req (draw_map_req),
        .oled_granted (oled_granted),
        .i2c_busy     (i2c_busy),
        .i2c_done     (i2c_done),
        .map_busy     (map_busy),
        .oled_req     (oled_req),
        .i2c_start    (i2c_start),
        .i2c_stop     (i2c_stop),
        .i2c_write    (i2c_write),
        .i2c_data_in  (i2c_data_in)
    );

    // maze rule with borders and a wall every 16 columns on even pages
    function automatic logic [7:0] map_rule(input int p, input int c);
        if (c == 0 || c == 127) return 8'hff;
        if (c % 16 == 0 && p % 2 == 0) return 8'hff;
        if (p == 0) return 8'h01;
        if (p == 7) return 8'h80;
        return 8'h00;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("FAIL time=%0t %s expected=0x%0h got=0x%0h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // full event stream of one map with command then data per page
    task automatic queue_expected();
        exp_events.delete();
        for (int p = 0; p < 8; p++) begin
            exp_events.push_back(256 | 8'h78);
            exp_events.push_back(8'h00);
            exp_events.push_back(8'hb0 + p);
            exp_events.push_back(8'h00);
            exp_events.push_back(8'h10);
            exp_events.push_back(512);
            exp_events.push_back(256 | 8'h78);
            exp_events.push_back(8'h40);
            for (int c = 0; c < 128; c++) begin
                exp_events.push_back(1024 | map_rule(p, c));
            end
            exp_events.push_back(512);
        end
    endtask

    // compare each bus event in order
    always @(posedge clk) begin : bus_monitor
        int expected;
        if (log_valid) begin
            start_count = start_count + log_start;
            stop_count  = stop_count + log_stop;
            if (!log_stop) write_count++;
            assert (exp_events.size() > 0) else begin
                $display("unexpected bus event at time %0t after the end of the map", $time);
                error_count++;
            end
            if (exp_events.size() > 0) begin
                expected = exp_events.pop_front();
                check_value("i2c_start", log_start, expected[8]);
                check_value("i2c_stop", log_stop, expected[9]);
                if (!log_stop) check_value("i2c_data_in", log_byte, expected[7:0]);
                if (expected[10] && !log_stop) checksum = checksum + log_byte;
            end
        end
    end

    // run limit worked out from the vector lines
    always @(posedge clk) begin
        if (limit_ready) begin
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("timeout, the runs did not finish within %0d cycles", cycle_limit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    task automatic run_vector(input int idx);
        int errors_before;
        errors_before = error_count;
        @(posedge clk);
        reset        <= 1'b1;
        draw_map_req <= 1'b0;
        grant_delay  <= vec_fields[idx * 6];
        busy_delay   <= vec_fields[idx * 6 + 1];
        done_delay   <= vec_fields[idx * 6 + 2];
        jitter       <= vec_fields[idx * 6 + 3] != 0;
        queue_expected();
        start_count = 0;
        stop_count  = 0;
        write_count = 0;
        checksum    = '0;
        repeat (10) @(posedge clk);
        // everything quiet in reset
        check_value("i2c_start", i2c_start, 0);
        check_value("i2c_stop", i2c_stop, 0);
        check_value("i2c_write", i2c_write, 0);
        check_value("map_busy", map_busy, 0);
        check_value("oled_req", oled_req, 0);
        reset <= 1'b0;
        // no bus request without a draw request
        repeat (4) begin
            @(posedge clk);
            check_value("oled_req", oled_req, 0);
        end
        draw_map_req <= 1'b1;
        while (!map_busy) @(posedge clk);
        while (map_busy) @(posedge clk);
        // finished state holds with the request still up
        repeat (20) begin
            @(posedge clk);
            check_value("map_busy", map_busy, 0);
            check_value("oled_req", oled_req, 0);
        end
        @(negedge clk);
        check_value("start count", start_count, 16);
        check_value("stop count", stop_count, 16);
        check_value("write count", write_count, vec_fields[idx * 6 + 4]);
        check_value("data checksum", checksum, vec_fields[idx * 6 + 5]);
        check_value("pending bus events", exp_events.size(), 0);
        @(posedge clk);
        draw_map_req <= 1'b0;
        $display("run %0d grant %0d busy %0d done %0d jitter %0d: %0d errors", idx,
                 vec_fields[idx * 6], vec_fields[idx * 6 + 1], vec_fields[idx * 6 + 2],
                 vec_fields[idx * 6 + 3], error_count - errors_before);
    endtask

    initial begin : main
        int    fd;
        string line;
        int    g, b, d, j, w, s;
        reset        = 1'b1;
        draw_map_req = 1'b0;
        grant_delay  = 0;
        busy_delay   = 0;
        done_delay   = 0;
        jitter       = 1'b0;
        check_count  = 0;
        error_count  = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        limit_ready  = 1'b0;
        fd = $fopen("testbench/map_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the vector file testbench/map_vectors.txt");
            error_count++;
        end
        if (fd != 0) begin
            // comment lines hold no numbers and are skipped
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "%d %d %d %d %d %d", g, b, d, j, w, s) == 6) begin
                    vec_fields.push_back(g);
                    vec_fields.push_back(b);
                    vec_fields.push_back(d);
                    vec_fields.push_back(j);
                    vec_fields.push_back(w);
                    vec_fields.push_back(s);
                    cycle_limit += 1080 * (b + d + 10) + 16 * (g + 3) + 100;
                end
            end
            $fclose(fd);
        end
        assert (vec_fields.size() > 0) else begin
            $display("no test vectors were read");
            error_count++;
        end
        limit_ready = 1'b1;
        for (int i = 0; i < vec_fields.size() / 6; i++) begin
            run_vector(i);
        end
        $display("runs %0d, checks %0d, errors %0d", vec_fields.size() / 6, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== testbench/map_vectors.txt ====
# grant_delay busy_delay done_delay jitter expected_writes expected_checksum
# checksum is the modulo-256 sum of the 1024 map bytes, writes include address bytes
0 0 0 0 1080 75
2 0 0 0 1080 75
0 3 0 0 1080 75
0 0 4 0 1080 75
5 2 1 0 1080 75
2 2 2 0 1080 75
0 0 0 1 1080 75
3 1 2 1 1080 75
1 4 3 1 1080 75
6 0 2 1 1080 75

// ==== sim.f ====
hw/oled_map_pkg.sv
hw/maze_map_rom.sv
hw/map_cursor.sv
hw/map_tx_sequencer.sv
hw/oled_map_display_controller.sv
testbench/tb_clock_gen.sv
testbench/i2c_master_model.sv
testbench/tb_oled_map.sv

// ==== Bender.yml ====
package:
  name: oled_map_display

sources:
  - hw/oled_map_pkg.sv
  - hw/maze_map_rom.sv
  - hw/map_cursor.sv
  - hw/map_tx_sequencer.sv
  - hw/oled_map_display_controller.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/i2c_master_model.sv
      - testbench/tb_oled_map.sv
